/* rtl/mipsPkg.sv */
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam logic [dataWidth-1:0] resetVector = 32'hBFC0_0000;
    localparam logic [dataWidth-1:0] haltAddress = 32'h0000_0000;
    localparam logic [regAddrWidth-1:0] regV0 = 5'd2;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_SLTIU = 6'b001011,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } func_t;

    typedef enum logic [3:0] {
        ALU_AND, ALU_OR, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV, ALU_LUI, ALU_PASS_A
    } aluOp_t;

    // Source of the second ALU operand
    typedef enum logic [1:0] {
        IMM_REG,
        IMM_ZERO,
        IMM_SIGN
    } immKind_t;

    typedef enum logic [2:0] {
        FLOW_NONE,
        FLOW_BEQ,
        FLOW_BNE,
        FLOW_JUMP,
        FLOW_JREG
    } flowKind_t;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXEC, MEM, WRITEBACK, HALTED
    } cpuState_t;

    typedef struct packed {
        aluOp_t                  aluOp;
        immKind_t                immKind;
        flowKind_t               flowKind;
        logic [regAddrWidth-1:0] destReg;
        logic                    regWrite;
        logic                    memRead;
        logic                    memWrite;
    } decodedCtrl_t;

    typedef struct packed {
        logic [dataWidth-1:0] address;
        logic                 read;
        logic                 write;
        logic [dataWidth-1:0] writedata;
    } busReq_t;

endpackage

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu import mipsPkg::*; (
    input  aluOp_t               op,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  logic [4:0]           shamt,
    output logic [dataWidth-1:0] result,
    output logic                 zero
);

    logic [4:0] varShift;
    logic       lessSigned;
    logic       lessUnsigned;

    assign varShift = a[4:0];
    assign lessSigned = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (op)
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLT:    result = {{(dataWidth-1){1'b0}}, lessSigned};
            ALU_SLTU:   result = {{(dataWidth-1){1'b0}}, lessUnsigned};
            // Shifts act on the rt operand
            ALU_SLL:    result = b << shamt;
            ALU_SRL:    result = b >> shamt;
            ALU_SRA:    result = $signed(b) >>> shamt;
            ALU_SLLV:   result = b << varShift;
            ALU_SRLV:   result = b >> varShift;
            ALU_SRAV:   result = $signed(b) >>> varShift;
            ALU_LUI:    result = {b[15:0], 16'b0};
            ALU_PASS_A: result = a;
            default:    result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    write,
    input  logic [regAddrWidth-1:0] wrAddr,
    input  logic [dataWidth-1:0]    wrData,
    input  logic [regAddrWidth-1:0] rdAddrA,
    input  logic [regAddrWidth-1:0] rdAddrB,
    output logic [dataWidth-1:0]    rdDataA,
    output logic [dataWidth-1:0]    rdDataB,
    output logic [dataWidth-1:0]    v0
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (write && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];
    assign v0 = regs[regV0];

    // $zero stays zero across writes into it
    assert property (@(posedge clk) disable iff (rst) (rdAddrA == '0) |-> (rdDataA == '0));
    assert property (@(posedge clk) disable iff (rst) (rdAddrB == '0) |-> (rdDataB == '0));

endmodule

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import mipsPkg::*; (
    input  logic [dataWidth-1:0] instr,
    output decodedCtrl_t         ctrl
);

    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;

    assign rt = instr[20:16];
    assign rd = instr[15:11];

    always_comb begin
        // Unknown encodings fall through as a no-op
        ctrl = '0;
        ctrl.aluOp = ALU_ADD;
        ctrl.immKind = IMM_SIGN;
        ctrl.flowKind = FLOW_NONE;
        ctrl.destReg = rt;
        case (instr[31:26])
            OP_RTYPE: begin
                ctrl.immKind = IMM_REG;
                ctrl.destReg = rd;
                ctrl.regWrite = 1'b1;
                case (instr[5:0])
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_XOR:  ctrl.aluOp = ALU_XOR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    FN_SLTU: ctrl.aluOp = ALU_SLTU;
                    FN_SLL:  ctrl.aluOp = ALU_SLL;
                    FN_SRL:  ctrl.aluOp = ALU_SRL;
                    FN_SRA:  ctrl.aluOp = ALU_SRA;
                    FN_SLLV: ctrl.aluOp = ALU_SLLV;
                    FN_SRLV: ctrl.aluOp = ALU_SRLV;
                    FN_SRAV: ctrl.aluOp = ALU_SRAV;
                    FN_JR: begin
                        ctrl.aluOp = ALU_PASS_A;
                        ctrl.flowKind = FLOW_JREG;
                        ctrl.regWrite = 1'b0;
                    end
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            OP_ADDIU: ctrl.regWrite = 1'b1;
            OP_SLTI: begin
                ctrl.aluOp = ALU_SLT;
                ctrl.regWrite = 1'b1;
            end
            OP_SLTIU: begin
                ctrl.aluOp = ALU_SLTU;
                ctrl.regWrite = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.immKind = IMM_ZERO;
                ctrl.regWrite = 1'b1;
                case (instr[31:26])
                    OP_ANDI: ctrl.aluOp = ALU_AND;
                    OP_ORI:  ctrl.aluOp = ALU_OR;
                    OP_XORI: ctrl.aluOp = ALU_XOR;
                    default: ctrl.aluOp = ALU_LUI;
                endcase
            end
            OP_LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
            end
            OP_SW: ctrl.memWrite = 1'b1;
            OP_BEQ, OP_BNE: begin
                // Compare by subtraction, zero flag decides
                ctrl.aluOp = ALU_SUB;
                ctrl.immKind = IMM_REG;
                ctrl.flowKind = (instr[31:26] == OP_BEQ) ? FLOW_BEQ : FLOW_BNE;
            end
            OP_J: ctrl.flowKind = FLOW_JUMP;
            default: ctrl.regWrite = 1'b0;
        endcase
    end

endmodule

/* rtl/controlFsm.sv */
`timescale 1ns/1ps

module controlFsm import mipsPkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        waitrequest,
    input  logic [dataWidth-1:0]        readdata,
    input  decodedCtrl_t                ctrl,
    input  logic [dataWidth-1:0]        rdDataA,
    input  logic [dataWidth-1:0]        rdDataB,
    input  logic [dataWidth-1:0]        aluResult,
    input  logic                        aluZero,
    output busReq_t                     busReq,
    output logic                        active,
    output logic [dataWidth-1:0]        instr,
    output logic [regAddrWidth-1:0]     rdAddrA,
    output logic [regAddrWidth-1:0]     rdAddrB,
    output logic                        regWrite,
    output logic [regAddrWidth-1:0]     wrAddr,
    output logic [dataWidth-1:0]        wrData,
    output aluOp_t                      aluOp,
    output logic [dataWidth-1:0]        aluA,
    output logic [dataWidth-1:0]        aluB,
    output logic [4:0]                  shamt
);

    cpuState_t            state;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] pendingTarget;
    logic [dataWidth-1:0] flowTarget;
    logic [dataWidth-1:0] storeData;
    logic [dataWidth-1:0] immSext;
    logic [dataWidth-1:0] operandB;
    // 0 idle, 1 after a taken branch, 2 while the delay slot runs
    logic [1:0]           delayStep;
    logic                 branchTaken;
    logic                 memAccess;

    assign pcPlus4 = pc + 32'd4;
    assign immSext = {{16{instr[15]}}, instr[15:0]};
    assign memAccess = ctrl.memRead || ctrl.memWrite;

    always_comb begin
        case (ctrl.immKind)
            IMM_ZERO: operandB = {16'b0, instr[15:0]};
            IMM_SIGN: operandB = immSext;
            default:  operandB = rdDataB;
        endcase
        case (ctrl.flowKind)
            FLOW_JUMP: flowTarget = {pcPlus4[31:28], instr[25:0], 2'b00};
            FLOW_JREG: flowTarget = rdDataA;
            default:   flowTarget = pcPlus4 + {immSext[29:0], 2'b00};
        endcase
        case (ctrl.flowKind)
            FLOW_BEQ:             branchTaken = aluZero;
            FLOW_BNE:             branchTaken = !aluZero;
            FLOW_JUMP, FLOW_JREG: branchTaken = 1'b1;
            default:              branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        busReq.address = pc;
        busReq.read = (state == FETCH) && (pc != haltAddress);
        busReq.write = 1'b0;
        busReq.writedata = storeData;
        if (state == MEM) begin
            busReq.address = {aluResult[dataWidth-1:2], 2'b00};
            busReq.read = ctrl.memRead;
            busReq.write = ctrl.memWrite;
        end
    end

    assign regWrite = (state == WRITEBACK) && ctrl.regWrite;
    assign wrAddr = ctrl.destReg;
    assign wrData = ctrl.memRead ? readdata : aluResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
            pc <= resetVector;
            active <= 1'b1;
            delayStep <= 2'd0;
        end else begin
            case (state)
                FETCH: begin
                    if (pc == haltAddress) begin
                        state <= HALTED;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= DECODE;
                    end
                end
                DECODE: state <= EXEC;
                EXEC: state <= MEM;
                MEM: begin
                    if (!(memAccess && waitrequest)) begin
                        state <= WRITEBACK;
                    end
                    // Branches in a delay slot are ignored
                    if (branchTaken && delayStep == 2'd0) begin
                        delayStep <= 2'd1;
                    end
                end
                WRITEBACK: begin
                    state <= FETCH;
                    if (delayStep == 2'd2) begin
                        pc <= pendingTarget;
                        delayStep <= 2'd0;
                    end else begin
                        pc <= pcPlus4;
                        if (delayStep == 2'd1) begin
                            delayStep <= 2'd2;
                        end
                    end
                end
                default: state <= HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            instr <= readdata;
            rdAddrA <= readdata[25:21];
            rdAddrB <= readdata[20:16];
        end
        if (state == EXEC) begin
            aluOp <= ctrl.aluOp;
            aluA <= rdDataA;
            aluB <= operandB;
            shamt <= instr[10:6];
            storeData <= rdDataB;
            if (delayStep == 2'd0) begin
                pendingTarget <= flowTarget;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(busReq.read && busReq.write));
    // Request holds until the slave accepts it
    assert property (@(posedge clk) disable iff (rst)
        (busReq.read || busReq.write) && waitrequest |=> $stable(busReq));

endmodule

/* rtl/mipsCpuBus.sv */
`timescale 1ns/1ps

module mipsCpuBus import mipsPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 active,
    output logic [dataWidth-1:0] register_v0,
    // Avalon master
    output logic [dataWidth-1:0] address,
    output logic                 write,
    output logic                 read,
    input  logic                 waitrequest,
    output logic [dataWidth-1:0] writedata,
    output logic [3:0]           byteenable,
    input  logic [dataWidth-1:0] readdata
);

    busReq_t                 busReq;
    decodedCtrl_t            ctrl;
    logic [dataWidth-1:0]    instr;
    logic [regAddrWidth-1:0] rdAddrA;
    logic [regAddrWidth-1:0] rdAddrB;
    logic [dataWidth-1:0]    rdDataA;
    logic [dataWidth-1:0]    rdDataB;
    logic                    regWrite;
    logic [regAddrWidth-1:0] wrAddr;
    logic [dataWidth-1:0]    wrData;
    aluOp_t                  aluOp;
    logic [dataWidth-1:0]    aluA;
    logic [dataWidth-1:0]    aluB;
    logic [4:0]              shamt;
    logic [dataWidth-1:0]    aluResult;
    logic                    aluZero;

    assign address = busReq.address;
    assign read = busReq.read;
    assign write = busReq.write;
    assign writedata = busReq.writedata;
    // Word accesses only
    assign byteenable = 4'b1111;

    controlFsm controlFsm_i (
        .clk(clk), .rst(rst), .waitrequest(waitrequest), .readdata(readdata),
        .ctrl(ctrl), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .aluResult(aluResult), .aluZero(aluZero), .busReq(busReq), .active(active),
        .instr(instr), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .regWrite(regWrite),
        .wrAddr(wrAddr), .wrData(wrData), .aluOp(aluOp), .aluA(aluA), .aluB(aluB),
        .shamt(shamt)
    );

    instrDecoder instrDecoder_i (.instr(instr), .ctrl(ctrl));

    alu alu_i (
        .op(aluOp), .a(aluA), .b(aluB), .shamt(shamt), .result(aluResult), .zero(aluZero)
    );

    regFile regFile_i (
        .clk(clk), .rst(rst), .write(regWrite), .wrAddr(wrAddr), .wrData(wrData),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .v0(register_v0)
    );

endmodule

/* tests/tbMemory.sv */
`timescale 1ns/1ps

module tbMemory (
    input  logic        clk,
    input  logic        rst,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] address,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    output logic [31:0] readdata
);

    logic [31:0] mem [logic [31:0]];
    // Accepted writes in bus order
    logic [31:0] storeAddr [$];
    logic [31:0] storeData [$];
    integer      memSeed = 39151;
    int          stallLeft;
    int          nextStall;
    logic [31:0] wordAddr;

    // Words never loaded or written
    function automatic logic [31:0] fillWord(logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hA5A5_5A5A;
    endfunction

    function automatic logic [31:0] readWord(logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return fillWord(addr);
    endfunction

    function automatic int drawStall();
        logic [31:0] r;
        r = $random(memSeed);
        return int'(r[1:0]);
    endfunction

    task automatic loadWord(input logic [31:0] addr, input logic [31:0] data);
        mem[addr] = data;
    endtask

    initial begin
        waitrequest = 1'b0;
        readdata = '0;
        stallLeft = 0;
    end

    assign wordAddr = {address[31:2], 2'b00};

    always @(posedge clk) begin
        if (rst) begin
            waitrequest <= 1'b0;
            stallLeft <= 0;
        end else if (read || write) begin
            if (waitrequest) begin
                stallLeft <= stallLeft - 1;
                waitrequest <= (stallLeft > 1);
            end else begin
                // Access accepted at this edge
                if (write) begin
                    mem[wordAddr] = writedata;
                    storeAddr.push_back(wordAddr);
                    storeData.push_back(writedata);
                end else begin
                    readdata <= readWord(wordAddr);
                end
                nextStall = drawStall();
                stallLeft <= nextStall;
                waitrequest <= (nextStall != 0);
            end
        end
    end

endmodule

/* tests/mipsCpuBusTb.sv */
`timescale 1ns/1ps

module mipsCpuBusTb import mipsPkg::*; ();

    localparam int progLength = 200;
    localparam int dataWords = 64;
    localparam logic [31:0] dataBase = 32'h1000_0000;
    localparam logic [4:0] baseReg = 5'd16;
    localparam int timeoutCycles = progLength * (5 + 2 * 3) + 200;

    logic        clk;
    logic        rst;
    logic        active;
    logic        read;
    logic        write;
    logic        waitrequest;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic [31:0] writedata;
    logic [31:0] readdata;
    logic [3:0]  byteenable;

    logic [31:0] progWords [progLength];
    logic [31:0] dataInit [dataWords];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] expV0;
    integer      seed = 39151;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;

    logic        holdPending = 1'b0;
    logic        holdRead;
    logic        holdWrite;
    logic [31:0] holdAddr;
    logic [31:0] holdData;

    mipsCpuBus dut_i (
        .clk(clk), .rst(rst), .active(active), .register_v0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    tbMemory memory_i (
        .clk(clk), .rst(rst), .read(read), .write(write), .address(address),
        .writedata(writedata), .waitrequest(waitrequest), .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic flagError(input string msg);
        errorCount++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    function automatic int randBelow(int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic logic [31:0] encR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                         logic [4:0] sh, logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Random forward-only program that keeps the base register for LW and SW
    task automatic buildProgram();
        logic [5:0]  rFuncs [13];
        logic [5:0]  iOps [7];
        logic [31:0] r;
        logic [31:0] tAddr;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        int          kind;
        int          target;
        bit          lastFlow;
        rFuncs = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU,
                   FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
        iOps = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        lastFlow = 1'b0;
        progWords[0] = encI(OP_LUI, 5'd0, baseReg, dataBase[31:16]);
        progWords[1] = encI(OP_ORI, baseReg, baseReg, dataBase[15:0]);
        for (int i = 2; i < progLength - 2; i++) begin
            kind = randBelow(27);
            r = randWord();
            rs = 5'(randBelow(17));
            rt = 5'(randBelow(17));
            rd = 5'(1 + randBelow(15));
            // No flow in a delay slot or near the end
            if (kind >= 21 && kind <= 23 && (lastFlow || i > progLength - 5)) begin
                kind = 24;
            end
            lastFlow = (kind >= 21 && kind <= 23);
            target = i + 2 + randBelow(8);
            if (target > progLength - 3) begin
                target = progLength - 3;
            end
            tAddr = resetVector + 32'(target * 4);
            if (kind < 13) begin
                progWords[i] = encR(rs, rt, rd, r[10:6], rFuncs[kind]);
            end else if (kind < 20) begin
                progWords[i] = encI(iOps[kind - 13], rs, rd, r[15:0]);
            end else if (kind == 20) begin
                progWords[i] = encI(OP_LW, baseReg, rd, 16'(randBelow(dataWords) * 4));
            end else if (kind == 21) begin
                progWords[i] = encI(OP_BEQ, rs, rt, 16'(target - i - 1));
            end else if (kind == 22) begin
                progWords[i] = encI(OP_BNE, rs, rt, 16'(target - i - 1));
            end else if (kind == 23) begin
                progWords[i] = {OP_J, tAddr[27:2]};
            end else begin
                progWords[i] = encI(OP_SW, baseReg, rt, 16'(randBelow(dataWords) * 4));
            end
        end
        progWords[progLength - 2] = encR(5'd0, 5'd0, 5'd0, 5'd0, FN_JR);
        progWords[progLength - 1] = '0;
    endtask

    // Reference instruction-set model with delay slots
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] dmem [dataWords];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nextNpc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] res;
        logic [31:0] ea;
        logic [4:0]  sh;
        logic [4:0]  dst;
        bit          wr;
        int          steps;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        for (int k = 0; k < dataWords; k++) begin
            dmem[k] = dataInit[k];
        end
        pc = resetVector;
        npc = resetVector + 32'd4;
        steps = 0;
        while (pc != haltAddress && steps < 4 * progLength) begin
            ins = progWords[int'((pc - resetVector) >> 2)];
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            sext = {{16{ins[15]}}, ins[15:0]};
            zext = {16'b0, ins[15:0]};
            ea = a + sext;
            sh = ins[10:6];
            res = '0;
            wr = 1'b1;
            dst = ins[20:16];
            nextNpc = npc + 32'd4;
            case (ins[31:26])
                OP_RTYPE: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                        FN_SLTU: res = {31'b0, a < b};
                        FN_SLL:  res = b << sh;
                        FN_SRL:  res = b >> sh;
                        FN_SRA:  res = $signed(b) >>> sh;
                        FN_SLLV: res = b << a[4:0];
                        FN_SRLV: res = b >> a[4:0];
                        FN_SRAV: res = $signed(b) >>> a[4:0];
                        FN_JR: begin
                            wr = 1'b0;
                            nextNpc = a;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = ea;
                OP_SLTI:  res = {31'b0, $signed(a) < $signed(sext)};
                OP_SLTIU: res = {31'b0, a < sext};
                OP_ANDI:  res = a & zext;
                OP_ORI:   res = a | zext;
                OP_XORI:  res = a ^ zext;
                OP_LUI:   res = {ins[15:0], 16'b0};
                OP_LW:    res = dmem[int'((ea - dataBase) >> 2)];
                OP_SW: begin
                    wr = 1'b0;
                    dmem[int'((ea - dataBase) >> 2)] = b;
                    expAddr.push_back(ea);
                    expData.push_back(b);
                end
                OP_BEQ, OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (ins[31:26] == OP_BEQ)) begin
                        nextNpc = npc + {sext[29:0], 2'b00};
                    end
                end
                OP_J: begin
                    wr = 1'b0;
                    nextNpc = {npc[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
            end
            pc = npc;
            npc = nextNpc;
            steps++;
        end
        expV0 = regs[2];
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the core did not halt within %0d cycles", timeoutCycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Bus request must hold while stalled
    always @(negedge clk) begin
        if (rst) begin
            holdPending = 1'b0;
        end else begin
            if (holdPending && (address != holdAddr || read != holdRead
                    || write != holdWrite || (write && writedata != holdData))) begin
                flagError("bus request changed while waitrequest was high");
            end
            if (write && byteenable != 4'hF) begin
                flagError($sformatf("byteenable %h on a write", byteenable));
            end
            holdPending = (read || write) && waitrequest;
            holdAddr = address;
            holdRead = read;
            holdWrite = write;
            holdData = writedata;
        end
    end

    initial begin
        rst = 1'b1;
        buildProgram();
        for (int k = 0; k < progLength; k++) begin
            memory_i.loadWord(resetVector + 32'(k * 4), progWords[k]);
        end
        for (int k = 0; k < dataWords; k++) begin
            dataInit[k] = randWord();
            memory_i.loadWord(dataBase + 32'(k * 4), dataInit[k]);
        end
        runModel();

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkCount++;
        if (active !== 1'b1 || write !== 1'b0 || read !== 1'b1 || address !== resetVector) begin
            flagError($sformatf("after reset active=%b write=%b read=%b address=%h",
                active, write, read, address));
        end

        while (active === 1'b1) begin
            @(negedge clk);
        end
        repeat (20) begin
            @(negedge clk);
            checkCount++;
            if (read !== 1'b0 || write !== 1'b0 || active !== 1'b0) begin
                flagError("bus activity after halt");
            end
        end

        checkCount++;
        if (registerV0 !== expV0) begin
            flagError($sformatf("register_v0 %h, expected %h", registerV0, expV0));
        end
        checkCount++;
        if (memory_i.storeAddr.size() != expAddr.size()) begin
            flagError($sformatf("%0d stores seen, expected %0d",
                memory_i.storeAddr.size(), expAddr.size()));
        end
        for (int k = 0; k < expAddr.size() && k < memory_i.storeAddr.size(); k++) begin
            checkCount++;
            if (memory_i.storeAddr[k] !== expAddr[k] || memory_i.storeData[k] !== expData[k]) begin
                flagError($sformatf("store %0d wrote %h to %h, expected %h to %h", k,
                    memory_i.storeData[k], memory_i.storeAddr[k], expData[k], expAddr[k]));
            end
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
rtl/mipsPkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/instrDecoder.sv
rtl/controlFsm.sv
rtl/mipsCpuBus.sv
tests/tbMemory.sv
tests/mipsCpuBusTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module mipsCpuBusTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
